// ==== build.f ====
+incdir+tests
src/rv_decode_pkg.sv
src/rv_field_decode.sv
src/rv_issue_seq.sv
src/rv_decode_out.sv
src/rv_decoder.sv
tests/tb_rv_decoder.sv

// ==== src/rv_decode_out.sv ====
`timescale 1ns/1ps

module rv_decode_out (
  input  logic                                 clk_i,
  input  logic                                 rstn_i,
  input  rv_decode_pkg::field_t                field_i,
  input  logic [rv_decode_pkg::DATA_WIDTH-1:0] imm_i,
  input  logic [rv_decode_pkg::DATA_WIDTH-1:0] jal_target_i,
  input  rv_decode_pkg::issue_act_t            act_i,
  input  logic [rv_decode_pkg::DATA_WIDTH-1:0] instr_addr_i,
  output rv_decode_pkg::dec_ctrl_t             ctrl_o,
  output logic [rv_decode_pkg::DATA_WIDTH-1:0] imm_o,
  output rv_decode_pkg::jump_t                 jmp_o,
  output logic                                 ready_o,
  output logic                                 illegal_o,
  output logic [rv_decode_pkg::DATA_WIDTH-1:0] instr_addr_o
);

  rv_decode_pkg::dec_ctrl_t ctrl_d;
  rv_decode_pkg::jump_t     jmp_d;
  logic                     ready_d;
  logic                     writer;

  // Classes that produce an ALU result for rd
  assign writer = (field_i.cls == rv_decode_pkg::CLS_OP)    ||
                  (field_i.cls == rv_decode_pkg::CLS_OPIMM) ||
                  (field_i.cls == rv_decode_pkg::CLS_LUI)   ||
                  (field_i.cls == rv_decode_pkg::CLS_AUIPC) ||
                  (field_i.cls == rv_decode_pkg::CLS_JAL);

  //////////////////////////////
  // Next controls

  always_comb begin
    ctrl_d = '0;
    if (writer) begin
      ctrl_d.alu_sel   = field_i.alu_sel;
      ctrl_d.op_a_used = 1'b1;              // rs1, x0 for LUI, or the PC
      ctrl_d.op_b_used = field_i.uses_rs2;
      ctrl_d.is_imm    = ~field_i.uses_rs2;
      ctrl_d.use_pc    = (field_i.cls == rv_decode_pkg::CLS_AUIPC) ||
                         (field_i.cls == rv_decode_pkg::CLS_JAL);
      ctrl_d.alu_dest  = field_i.rd;
      ctrl_d.rf_addr_a = field_i.uses_rs1 ? field_i.rs1 : '0;
      ctrl_d.rf_addr_b = field_i.uses_rs2 ? field_i.rs2 : '0;
      ctrl_d.alu_wb    = (act_i != rv_decode_pkg::ACT_STALL);  // Stalled slot discards result
    end

    jmp_d       = '0;
    jmp_d.valid = (act_i == rv_decode_pkg::ACT_JAL_FIRST);
    if (jmp_d.valid) begin
      jmp_d.addr = jal_target_i;
    end

    // Fetch must hold the word while it still needs cycles here
    ready_d = !((act_i == rv_decode_pkg::ACT_STALL)     ||
                (act_i == rv_decode_pkg::ACT_JAL_FIRST) ||
                (act_i == rv_decode_pkg::ACT_JAL_WAIT));
  end

  //////////////////////////////
  // Output registers

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ctrl_o    <= '0;
      jmp_o     <= '0;
      ready_o   <= 1'b1;
      illegal_o <= 1'b0;
    end else begin
      ctrl_o    <= ctrl_d;
      jmp_o     <= jmp_d;
      ready_o   <= ready_d;
      illegal_o <= (field_i.cls == rv_decode_pkg::CLS_INVALID);
    end
  end

  always_ff @(posedge clk_i) begin
    imm_o        <= imm_i;
    instr_addr_o <= instr_addr_i;  // Travels with the controls
  end

endmodule

// ==== src/rv_decode_pkg.sv ====
package rv_decode_pkg;

  //////////////////////////////
  // Widths

  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int ALU_SEL_WIDTH  = 4;

  //////////////////////////////
  // RV32I encodings

  localparam logic [6:0] OPCODE_OP      = 7'b0110011;
  localparam logic [6:0] OPCODE_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI     = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPCODE_JAL     = 7'b1101111;
  localparam logic [6:0] OPCODE_MISCMEM = 7'b0001111;
  localparam logic [6:0] OPCODE_SYSTEM  = 7'b1110011;

  localparam logic [2:0] FUNCT3_SHIFT_L = 3'b001;  // SLLI
  localparam logic [2:0] FUNCT3_SHIFT_R = 3'b101;  // SRLI and SRAI, split by bit 30

  localparam logic [ALU_SEL_WIDTH-1:0] ALU_OP_ADD = 4'b0000;

  // Link value added to the PC for JAL
  localparam logic [DATA_WIDTH-1:0] PC_STEP = 32'd4;

  //////////////////////////////
  // Enums

  typedef enum logic [2:0] {
    CLS_OP      = 3'd0,
    CLS_OPIMM   = 3'd1,
    CLS_LUI     = 3'd2,
    CLS_AUIPC   = 3'd3,
    CLS_JAL     = 3'd4,
    CLS_NOP     = 3'd5,  // FENCE, SYSTEM and unknown opcodes
    CLS_INVALID = 3'd6   // No valid instruction this cycle
  } instr_class_t;

  typedef enum logic [2:0] {
    ACT_IDLE      = 3'd0,
    ACT_STALL     = 3'd1,
    ACT_EXEC      = 3'd2,
    ACT_JAL_FIRST = 3'd3,
    ACT_JAL_WAIT  = 3'd4,
    ACT_JAL_LAST  = 3'd5
  } issue_act_t;

  //////////////////////////////
  // Structs

  // Controls toward the ALU and register file
  typedef struct packed {
    logic [ALU_SEL_WIDTH-1:0]  alu_sel;
    logic                      op_a_used;
    logic                      op_b_used;
    logic                      is_imm;
    logic                      use_pc;
    logic                      alu_wb;
    logic [REG_ADDR_WIDTH-1:0] alu_dest;
    logic [REG_ADDR_WIDTH-1:0] rf_addr_a;
    logic [REG_ADDR_WIDTH-1:0] rf_addr_b;
  } dec_ctrl_t;

  typedef struct packed {
    logic                  valid;
    logic [DATA_WIDTH-1:0] addr;
  } jump_t;

  // Classifier result shared by the sequencer and the output stage
  typedef struct packed {
    instr_class_t              cls;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic                      uses_rs1;
    logic                      uses_rs2;
    logic [ALU_SEL_WIDTH-1:0]  alu_sel;
  } field_t;

endpackage

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic                                 clk_i,
  input  logic                                 rstn_i,
  input  logic [rv_decode_pkg::DATA_WIDTH-1:0] instr_i,
  input  logic [rv_decode_pkg::DATA_WIDTH-1:0] instr_addr_i,
  input  logic                                 instr_valid_i,
  output rv_decode_pkg::dec_ctrl_t             ctrl_o,
  output logic [rv_decode_pkg::DATA_WIDTH-1:0] imm_o,
  output rv_decode_pkg::jump_t                 jmp_o,
  output logic                                 ready_o,
  output logic                                 illegal_o,
  output logic [rv_decode_pkg::DATA_WIDTH-1:0] instr_addr_o
);

  rv_decode_pkg::field_t                field;
  logic [rv_decode_pkg::DATA_WIDTH-1:0] imm;
  logic [rv_decode_pkg::DATA_WIDTH-1:0] jal_target;
  rv_decode_pkg::issue_act_t            act;

  // Combinational field extraction
  rv_field_decode rv_field_decode_inst (
    .instr_i       (instr_i),
    .instr_addr_i  (instr_addr_i),
    .field_o       (field),
    .imm_o         (imm),
    .jal_target_o  (jal_target),
    .instr_valid_i (instr_valid_i)
  );

  rv_issue_seq rv_issue_seq_inst (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .field_i (field),
    .act_o   (act)
  );

  // Single register stage toward execute and fetch
  rv_decode_out rv_decode_out_inst (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .field_i      (field),
    .imm_i        (imm),
    .jal_target_i (jal_target),
    .act_i        (act),
    .instr_addr_i (instr_addr_i),
    .ctrl_o       (ctrl_o),
    .imm_o        (imm_o),
    .jmp_o        (jmp_o),
    .ready_o      (ready_o),
    .illegal_o    (illegal_o),
    .instr_addr_o (instr_addr_o)
  );

endmodule

// ==== src/rv_field_decode.sv ====
`timescale 1ns/1ps

module rv_field_decode (
  input  logic [rv_decode_pkg::DATA_WIDTH-1:0] instr_i,
  input  logic [rv_decode_pkg::DATA_WIDTH-1:0] instr_addr_i,
  output rv_decode_pkg::field_t                field_o,
  output logic [rv_decode_pkg::DATA_WIDTH-1:0] imm_o,
  output logic [rv_decode_pkg::DATA_WIDTH-1:0] jal_target_o,
  input  logic                                 instr_valid_i
);

  logic [6:0]                            opcode;
  logic [2:0]                            funct3;
  logic                                  is_shift;
  logic [rv_decode_pkg::DATA_WIDTH-1:0]  i_imm;
  logic [rv_decode_pkg::DATA_WIDTH-1:0]  shamt_imm;
  logic [rv_decode_pkg::DATA_WIDTH-1:0]  u_imm;
  logic [rv_decode_pkg::DATA_WIDTH-1:0]  j_imm;

  assign opcode   = instr_i[6:0];
  assign funct3   = instr_i[14:12];
  assign is_shift = (funct3 == rv_decode_pkg::FUNCT3_SHIFT_L) ||
                    (funct3 == rv_decode_pkg::FUNCT3_SHIFT_R);

  //////////////////////////////
  // Immediate formats

  assign i_imm     = {{20{instr_i[31]}}, instr_i[31:20]};
  assign shamt_imm = {27'b0, instr_i[24:20]};  // Shift amount is unsigned
  assign u_imm     = {instr_i[31:12], 12'b0};
  assign j_imm     = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                      instr_i[20], instr_i[30:21], 1'b0};

  // Dedicated adder for the JAL target
  assign jal_target_o = instr_addr_i + j_imm;

  //////////////////////////////
  // Opcode classification

  always_comb begin
    field_o          = '0;
    field_o.cls      = rv_decode_pkg::CLS_NOP;
    field_o.rd       = instr_i[11:7];
    field_o.rs1      = instr_i[19:15];
    field_o.rs2      = instr_i[24:20];
    imm_o            = '0;

    if (!instr_valid_i) begin
      field_o.cls = rv_decode_pkg::CLS_INVALID;
    end else begin
      case (opcode)
        rv_decode_pkg::OPCODE_OP: begin
          field_o.cls      = rv_decode_pkg::CLS_OP;
          field_o.uses_rs1 = 1'b1;
          field_o.uses_rs2 = 1'b1;
          field_o.alu_sel  = {instr_i[30], funct3};  // Bit 30 picks SUB and SRA
        end
        rv_decode_pkg::OPCODE_OPIMM: begin
          field_o.cls      = rv_decode_pkg::CLS_OPIMM;
          field_o.uses_rs1 = 1'b1;
          if (is_shift) begin
            field_o.alu_sel = {instr_i[30], funct3};
            imm_o           = shamt_imm;
          end else begin
            field_o.alu_sel = {1'b0, funct3};
            imm_o           = i_imm;
          end
        end
        rv_decode_pkg::OPCODE_LUI: begin
          field_o.cls     = rv_decode_pkg::CLS_LUI;
          field_o.alu_sel = rv_decode_pkg::ALU_OP_ADD;
          imm_o           = u_imm;
        end
        rv_decode_pkg::OPCODE_AUIPC: begin
          field_o.cls     = rv_decode_pkg::CLS_AUIPC;
          field_o.alu_sel = rv_decode_pkg::ALU_OP_ADD;
          imm_o           = u_imm;
        end
        rv_decode_pkg::OPCODE_JAL: begin
          field_o.cls     = rv_decode_pkg::CLS_JAL;
          field_o.alu_sel = rv_decode_pkg::ALU_OP_ADD;  // pc + 4 into rd
          imm_o           = rv_decode_pkg::PC_STEP;
        end
        rv_decode_pkg::OPCODE_MISCMEM,
        rv_decode_pkg::OPCODE_SYSTEM: field_o.cls = rv_decode_pkg::CLS_NOP;  // Fences, ecall
        default: field_o.cls = rv_decode_pkg::CLS_NOP;
      endcase
    end
  end

endmodule

// ==== src/rv_issue_seq.sv ====
`timescale 1ns/1ps

module rv_issue_seq (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  rv_decode_pkg::field_t     field_i,
  output rv_decode_pkg::issue_act_t act_o
);

  // Destination of the instruction issued on the last edge
  logic [rv_decode_pkg::REG_ADDR_WIDTH-1:0] prev_dest_q;
  rv_decode_pkg::issue_act_t                prev_act_q;

  logic hit_rs1;
  logic hit_rs2;
  logic raw_hazard;
  logic writes_rd;

  //////////////////////////////
  // Hazard detection

  assign hit_rs1 = field_i.uses_rs1 && (field_i.rs1 == prev_dest_q);
  assign hit_rs2 = field_i.uses_rs2 && (field_i.rs2 == prev_dest_q);

  // x0 never creates a dependency, and a stall is inserted only once
  assign raw_hazard = (hit_rs1 || hit_rs2) &&
                      (prev_dest_q != '0) &&
                      (prev_act_q != rv_decode_pkg::ACT_STALL);

  //////////////////////////////
  // Action select

  always_comb begin
    act_o = rv_decode_pkg::ACT_IDLE;
    case (field_i.cls)
      rv_decode_pkg::CLS_OP,
      rv_decode_pkg::CLS_OPIMM: begin
        if (raw_hazard) begin
          act_o = rv_decode_pkg::ACT_STALL;
        end else begin
          act_o = rv_decode_pkg::ACT_EXEC;
        end
      end

      // Upper immediates read no register
      rv_decode_pkg::CLS_LUI,
      rv_decode_pkg::CLS_AUIPC: act_o = rv_decode_pkg::ACT_EXEC;

      rv_decode_pkg::CLS_JAL: begin
        // Three steps per JAL, fetch holds the word meanwhile
        case (prev_act_q)
          rv_decode_pkg::ACT_JAL_FIRST: act_o = rv_decode_pkg::ACT_JAL_WAIT;
          rv_decode_pkg::ACT_JAL_WAIT:  act_o = rv_decode_pkg::ACT_JAL_LAST;
          default:                      act_o = rv_decode_pkg::ACT_JAL_FIRST;
        endcase
      end

      default: act_o = rv_decode_pkg::ACT_IDLE;  // No-op and invalid cycles
    endcase
  end

  // Actions that put a result into rd
  always_comb begin
    case (act_o)
      rv_decode_pkg::ACT_EXEC,
      rv_decode_pkg::ACT_JAL_FIRST,
      rv_decode_pkg::ACT_JAL_WAIT,
      rv_decode_pkg::ACT_JAL_LAST: writes_rd = 1'b1;
      default:                     writes_rd = 1'b0;
    endcase
  end

  //////////////////////////////
  // State update

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_dest_q <= '0;
      prev_act_q  <= rv_decode_pkg::ACT_IDLE;
    end else begin
      prev_act_q <= act_o;
      if (writes_rd) begin
        prev_dest_q <= field_i.rd;
      end else begin
        prev_dest_q <= '0;  // Stalls and no-ops leave nothing pending
      end
    end
  end

endmodule

// ==== tests/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

//////////////////////////////
// Decode stage reference model

function automatic rv_decode_pkg::instr_class_t model_class(
  input logic [31:0] instr,
  input logic        valid
);
  if (!valid) begin
    return rv_decode_pkg::CLS_INVALID;
  end
  case (instr[6:0])
    rv_decode_pkg::OPCODE_OP:    return rv_decode_pkg::CLS_OP;
    rv_decode_pkg::OPCODE_OPIMM: return rv_decode_pkg::CLS_OPIMM;
    rv_decode_pkg::OPCODE_LUI:   return rv_decode_pkg::CLS_LUI;
    rv_decode_pkg::OPCODE_AUIPC: return rv_decode_pkg::CLS_AUIPC;
    rv_decode_pkg::OPCODE_JAL:   return rv_decode_pkg::CLS_JAL;
    default:                     return rv_decode_pkg::CLS_NOP;  // FENCE, SYSTEM, unknown
  endcase
endfunction

function automatic logic is_shift(input logic [31:0] instr);
  return (instr[14:12] == rv_decode_pkg::FUNCT3_SHIFT_L) ||
         (instr[14:12] == rv_decode_pkg::FUNCT3_SHIFT_R);
endfunction

function automatic logic [31:0] model_imm(
  input logic [31:0]                 instr,
  input rv_decode_pkg::instr_class_t cls
);
  case (cls)
    rv_decode_pkg::CLS_OPIMM: begin
      if (is_shift(instr)) begin
        return {27'b0, instr[24:20]};
      end
      return {{20{instr[31]}}, instr[31:20]};
    end
    rv_decode_pkg::CLS_LUI,
    rv_decode_pkg::CLS_AUIPC: return {instr[31:12], 12'b0};
    rv_decode_pkg::CLS_JAL:   return rv_decode_pkg::PC_STEP;
    default:                  return 32'b0;
  endcase
endfunction

// Action for this cycle from the model copy of the sequencer state
function automatic rv_decode_pkg::issue_act_t model_act(
  input logic [31:0]                 instr,
  input rv_decode_pkg::instr_class_t cls,
  input logic [4:0]                  prev_dest,
  input rv_decode_pkg::issue_act_t   prev_act
);
  logic hit;
  hit = (instr[19:15] == prev_dest) ||
        ((cls == rv_decode_pkg::CLS_OP) && (instr[24:20] == prev_dest));
  if ((cls == rv_decode_pkg::CLS_OP) || (cls == rv_decode_pkg::CLS_OPIMM)) begin
    if (hit && (prev_dest != 5'd0) && (prev_act != rv_decode_pkg::ACT_STALL)) begin
      return rv_decode_pkg::ACT_STALL;
    end
    return rv_decode_pkg::ACT_EXEC;
  end
  if ((cls == rv_decode_pkg::CLS_LUI) || (cls == rv_decode_pkg::CLS_AUIPC)) begin
    return rv_decode_pkg::ACT_EXEC;
  end
  if (cls == rv_decode_pkg::CLS_JAL) begin
    if (prev_act == rv_decode_pkg::ACT_JAL_FIRST) begin
      return rv_decode_pkg::ACT_JAL_WAIT;
    end
    if (prev_act == rv_decode_pkg::ACT_JAL_WAIT) begin
      return rv_decode_pkg::ACT_JAL_LAST;
    end
    return rv_decode_pkg::ACT_JAL_FIRST;
  end
  return rv_decode_pkg::ACT_IDLE;
endfunction

function automatic rv_decode_pkg::dec_ctrl_t model_ctrl(
  input logic [31:0]                 instr,
  input rv_decode_pkg::instr_class_t cls,
  input rv_decode_pkg::issue_act_t   act
);
  rv_decode_pkg::dec_ctrl_t c;
  logic                     writer;
  c      = '0;
  writer = 1'b1;
  case (cls)
    rv_decode_pkg::CLS_OP: begin
      c.alu_sel   = {instr[30], instr[14:12]};
      c.op_b_used = 1'b1;
      c.rf_addr_a = instr[19:15];
      c.rf_addr_b = instr[24:20];
    end
    rv_decode_pkg::CLS_OPIMM: begin
      c.alu_sel   = is_shift(instr) ? {instr[30], instr[14:12]} : {1'b0, instr[14:12]};
      c.rf_addr_a = instr[19:15];
    end
    rv_decode_pkg::CLS_LUI:   c.alu_sel = rv_decode_pkg::ALU_OP_ADD;
    rv_decode_pkg::CLS_AUIPC,
    rv_decode_pkg::CLS_JAL: begin
      c.alu_sel = rv_decode_pkg::ALU_OP_ADD;
      c.use_pc  = 1'b1;  // pc + imm
    end
    default: writer = 1'b0;
  endcase
  if (writer) begin
    c.op_a_used = 1'b1;
    c.is_imm    = !c.op_b_used;
    c.alu_dest  = instr[11:7];
    c.alu_wb    = (act != rv_decode_pkg::ACT_STALL);
  end
  return c;
endfunction

function automatic rv_decode_pkg::jump_t model_jump(
  input logic [31:0]               instr,
  input logic [31:0]               addr,
  input rv_decode_pkg::issue_act_t act
);
  rv_decode_pkg::jump_t j;
  logic [31:0]          offset;
  j      = '0;
  offset = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};  // J-type
  if (act == rv_decode_pkg::ACT_JAL_FIRST) begin
    j.valid = 1'b1;
    j.addr  = addr + offset;
  end
  return j;
endfunction

function automatic logic model_ready(input rv_decode_pkg::issue_act_t act);
  return (act != rv_decode_pkg::ACT_STALL) && (act != rv_decode_pkg::ACT_JAL_FIRST) &&
         (act != rv_decode_pkg::ACT_JAL_WAIT);
endfunction

// Destination recorded for the next cycle's hazard check
function automatic logic [4:0] model_next_dest(
  input logic [31:0]               instr,
  input rv_decode_pkg::issue_act_t act
);
  if ((act == rv_decode_pkg::ACT_IDLE) || (act == rv_decode_pkg::ACT_STALL)) begin
    return 5'd0;
  end
  return instr[11:7];
endfunction

`endif

// ==== tests/tb_rv_decoder.sv ====
`timescale 1ns/1ps

module tb_rv_decoder;

  localparam int NUM_INSTR  = 400;
  localparam int CLK_PERIOD = 10;
  localparam int TIMEOUT_NS = NUM_INSTR * 4 * CLK_PERIOD + 200;

  logic                     clk;
  logic                     rstn;
  logic [31:0]              instr;
  logic [31:0]              instr_addr;
  logic                     instr_valid;
  rv_decode_pkg::dec_ctrl_t ctrl;
  logic [31:0]              imm;
  rv_decode_pkg::jump_t     jmp;
  logic                     ready;
  logic                     illegal;
  logic [31:0]              instr_addr_out;

  integer                    seed;
  int                        ctrl_errs;
  int                        imm_errs;
  int                        jump_errs;
  int                        flag_errs;
  int                        addr_errs;
  int                        other_errs;
  int                        stall_cnt;
  int                        jal_cnt;
  logic [4:0]                prev_dest;  // Model copy of the sequencer state
  rv_decode_pkg::issue_act_t prev_act;

  `include "decode_model.svh"

  rv_decoder rv_decoder_inst (
    .clk_i         (clk),
    .rstn_i        (rstn),
    .instr_i       (instr),
    .instr_addr_i  (instr_addr),
    .instr_valid_i (instr_valid),
    .ctrl_o        (ctrl),
    .imm_o         (imm),
    .jmp_o         (jmp),
    .ready_o       (ready),
    .illegal_o     (illegal),
    .instr_addr_o  (instr_addr_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: %0d instructions not done within %0d ns", NUM_INSTR, TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////
  // Compare tasks

  task automatic check_ctrl(input rv_decode_pkg::dec_ctrl_t got,
                            input rv_decode_pkg::dec_ctrl_t exp, input string what);
    if (got !== exp) begin
      ctrl_errs++;
      $display("Mismatch at time %0t: ctrl_o %h, expected %h (%s)", $time, got, exp, what);
    end
  endtask

  task automatic check_imm(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      imm_errs++;
      $display("Mismatch at time %0t: imm_o %h, expected %h (%s)", $time, got, exp, what);
    end
  endtask

  task automatic check_jump(input rv_decode_pkg::jump_t got, input rv_decode_pkg::jump_t exp,
                            input string what);
    if (got !== exp) begin
      jump_errs++;
      $display("Mismatch at time %0t: jmp_o %h, expected %h (%s)", $time, got, exp, what);
    end
  endtask

  task automatic check_flags(input logic got_ready, input logic exp_ready,
                             input logic got_illegal, input logic exp_illegal, input string what);
    if ((got_ready !== exp_ready) || (got_illegal !== exp_illegal)) begin
      flag_errs++;
      $display("Mismatch at time %0t: ready/illegal %b/%b, expected %b/%b (%s)",
               $time, got_ready, got_illegal, exp_ready, exp_illegal, what);
    end
  endtask

  task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      addr_errs++;
      $display("Mismatch at time %0t: instr_addr_o %h, expected %h (%s)",
               $time, got, exp, what);
    end
  endtask

  //////////////////////////////
  // Stimulus

  // Weighted opcode pick, register indices kept small so hazards are frequent
  task automatic drive_random_instr(input logic [31:0] pc);
    int unsigned pick;
    logic [31:0] word;
    pick        = $unsigned($random(seed)) % 16;
    word        = $random(seed);
    word[11:7]  = $unsigned($random(seed)) % 4;
    case (pick)
      0, 1, 2, 3: begin
        word[6:0]   = rv_decode_pkg::OPCODE_OP;
        word[19:15] = $unsigned($random(seed)) % 4;
        word[24:20] = $unsigned($random(seed)) % 4;
      end
      4, 5, 6, 7: begin
        word[6:0]   = rv_decode_pkg::OPCODE_OPIMM;
        word[19:15] = $unsigned($random(seed)) % 4;  // Shift amount stays random
      end
      8:       word[6:0] = rv_decode_pkg::OPCODE_LUI;
      9:       word[6:0] = rv_decode_pkg::OPCODE_AUIPC;
      10, 11:  word[6:0] = rv_decode_pkg::OPCODE_JAL;
      12:      word[6:0] = rv_decode_pkg::OPCODE_MISCMEM;
      13:      word[6:0] = rv_decode_pkg::OPCODE_SYSTEM;
      14:      word[6:0] = 7'b0101011;  // Unused custom opcode
      default: word[6:0] = word[6:0];   // Random bits, sent with valid low
    endcase
    instr       = word;
    instr_addr  = pc;
    instr_valid = (pick != 15);
  endtask

  initial begin
    logic [31:0]                  pc;
    int                           retired;
    string                        what;
    rv_decode_pkg::instr_class_t  cls;
    rv_decode_pkg::issue_act_t    act;

    seed        = 32'h9a45a842;
    rstn        = 1'b0;
    instr       = '0;
    instr_addr  = '0;
    instr_valid = 1'b0;
    ctrl_errs   = 0;
    imm_errs    = 0;
    jump_errs   = 0;
    flag_errs   = 0;
    addr_errs   = 0;
    other_errs  = 0;
    stall_cnt   = 0;
    jal_cnt     = 0;
    prev_dest   = '0;
    prev_act    = rv_decode_pkg::ACT_IDLE;

    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;
    check_ctrl(ctrl, '0, "after reset");
    check_jump(jmp, '0, "after reset");
    check_flags(ready, 1'b1, illegal, 1'b0, "after reset");

    pc      = 32'h0000_1000;
    retired = 0;
    drive_random_instr(pc);

    while (retired < NUM_INSTR) begin
      @(posedge clk);
      #1;
      cls  = model_class(instr, instr_valid);
      act  = model_act(instr, cls, prev_dest, prev_act);
      what = $sformatf("instr %h at %h", instr, instr_addr);
      check_ctrl(ctrl, model_ctrl(instr, cls, act), what);
      check_imm(imm, model_imm(instr, cls), what);
      check_jump(jmp, model_jump(instr, instr_addr, act), what);
      check_flags(ready, model_ready(act), illegal, cls == rv_decode_pkg::CLS_INVALID, what);
      check_addr(instr_addr_out, instr_addr, what);
      if (act == rv_decode_pkg::ACT_STALL) stall_cnt++;
      if (act == rv_decode_pkg::ACT_JAL_FIRST) jal_cnt++;
      prev_dest = model_next_dest(instr, act);
      prev_act  = act;
      // Fetch holds the word until the registered ready comes back high
      if (ready) begin
        retired++;
        pc = pc + 32'd4;
        drive_random_instr(pc);
      end
    end

    if ((stall_cnt == 0) || (jal_cnt == 0)) begin
      other_errs++;
      $display("Error: stream gave %0d stalls and %0d jumps, expected some of each",
               stall_cnt, jal_cnt);
    end
    $display("Errors: ctrl %0d, imm %0d, jump %0d, flags %0d, addr %0d, other %0d",
             ctrl_errs, imm_errs, jump_errs, flag_errs, addr_errs, other_errs);
    if ((ctrl_errs + imm_errs + jump_errs + flag_errs + addr_errs + other_errs) == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
